/* include/touch_macros.svh */
`ifndef TOUCH_MACROS_SVH
`define TOUCH_MACROS_SVH

// serial clock half-period in cclk cycles
`define TOUCH_CLK_DIV_COUNT 25

// frame sizes on the serial link
`define TOUCH_CMD_BITS 8
`define TOUCH_RESULT_BITS 12

// conversions per channel, only the last one is kept
`define TOUCH_SETTLE_CONVERSIONS 8

// panel calibration, raw counts at the left and top edges
`define TOUCH_X_ADJ_MIN 12'h096
`define TOUCH_Y_ADJ_MIN 12'h12C

// screen is 480 x 273
`define TOUCH_X_MAX 9'd479
`define TOUCH_Y_MAX 9'd272

// moving average over 8 samples
`define TOUCH_AVG_LOG_DEPTH 3

`endif

/* logic/touch_pkg.sv */
`default_nettype none

package touch_pkg;

	// measured channel, also the rotation order
	typedef enum logic [1:0] {
		CH_X = 2'd0,
		CH_Y = 2'd1,
		CH_Z = 2'd2
	} channel_e;

	// control byte fields, msb first on the wire
	typedef struct packed {
		logic       start;   // always 1
		logic [2:0] addr;    // A2..A0
		logic       mode;    // 0 selects 12-bit
		logic       ser_dfr; // 0 selects differential
		logic [1:0] pd;      // PD1..PD0
	} touch_cmd_fields_t;

	// sequencer fills the fields, link shifts the raw byte
	typedef union packed {
		logic [7:0]        raw;
		touch_cmd_fields_t f;
	} touch_cmd_u;

endpackage

`default_nettype wire

/* logic/touch_averager.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_averager #(
	parameter int WIDTH = 9,
	parameter int LOG_DEPTH = 3
) (
	input wire cclk,
	input wire rstb,
	input wire ena,
	input wire [WIDTH-1:0] sample,
	output logic [WIDTH-1:0] average
);

	localparam int DEPTH = 1 << LOG_DEPTH;
	localparam int SUM_W = WIDTH + LOG_DEPTH;

	logic [WIDTH-1:0] window [DEPTH];
	logic [SUM_W-1:0] sum;

	// sum is always the total of the window
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < DEPTH; i++)
				window[i] <= '0;
			sum <= '0;
		end else if (ena) begin
			window[0] <= sample;
			for (int i = 1; i < DEPTH; i++)
				window[i] <= window[i-1];
			sum <= sum + SUM_W'(sample) - SUM_W'(window[DEPTH-1]); // oldest drops out
		end
	end

	always_ff @(posedge cclk) begin
		if (!rstb)
			average <= '0;
		else
			average <= sum[SUM_W-1:LOG_DEPTH];
	end

endmodule

`default_nettype wire

/* logic/touch_serial_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "touch_macros.svh"

module touch_serial_link (
	input wire cclk,
	input wire rstb,
	input wire conv_start,
	input wire touch_pkg::touch_cmd_u cmd,
	input wire touch_busy,
	input wire data_in,
	output logic touch_clk,
	output logic data_out,
	output logic touch_csb,
	output logic conv_done,
	output logic [`TOUCH_RESULT_BITS-1:0] conv_data
);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_CMD,
		PH_BUSY,
		PH_RESULT
	} phase_e;

	localparam int DIV_W = $clog2(`TOUCH_CLK_DIV_COUNT);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`TOUCH_CLK_DIV_COUNT - 1);
	localparam logic [3:0] CMD_LAST = 4'(`TOUCH_CMD_BITS - 1);
	localparam logic [3:0] RESULT_BITS = 4'(`TOUCH_RESULT_BITS);

	phase_e phase;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0] bit_cnt;
	logic [`TOUCH_CMD_BITS-1:0] tx_shift;
	logic [`TOUCH_RESULT_BITS-1:0] rx_shift;
	logic sclk;
	logic edge_tick;
	logic rise;
	logic fall;

	// serial clock only runs inside a transaction
	assign edge_tick = (phase != PH_IDLE) && (div_cnt == DIV_LAST);
	assign rise = edge_tick && !sclk;
	assign fall = edge_tick && sclk;

	assign touch_clk = sclk;
	assign data_out = tx_shift[`TOUCH_CMD_BITS-1];
	assign conv_data = rx_shift;

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			phase <= PH_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			sclk <= 1'b0;
			tx_shift <= '0;
			conv_done <= 1'b0;
			touch_csb <= 1'b1;
		end else begin
			touch_csb <= 1'b0; // converter stays selected
			conv_done <= 1'b0;
			if (phase == PH_IDLE || div_cnt == DIV_LAST)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			if (edge_tick)
				sclk <= !sclk;
			case (phase)
				PH_IDLE: begin
					if (conv_start) begin
						tx_shift <= cmd.raw; // msb is on the pin before the first rise
						bit_cnt <= '0;
						phase <= PH_CMD;
					end
				end
				PH_CMD: begin
					if (fall) begin
						tx_shift <= {tx_shift[`TOUCH_CMD_BITS-2:0], 1'b0};
						if (bit_cnt == CMD_LAST) begin
							bit_cnt <= '0;
							phase <= PH_BUSY;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				PH_BUSY: begin
					// clock keeps running, busy checked on rising edges
					if (rise && !touch_busy)
						phase <= PH_RESULT;
				end
				PH_RESULT: begin
					if (rise)
						bit_cnt <= bit_cnt + 1'b1;
					if (fall && bit_cnt == RESULT_BITS) begin
						bit_cnt <= '0;
						conv_done <= 1'b1;
						phase <= PH_IDLE;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// result bits, msb first
	always_ff @(posedge cclk) begin
		if (phase == PH_RESULT && rise)
			rx_shift <= {rx_shift[`TOUCH_RESULT_BITS-2:0], data_in};
	end

	// one conversion in flight at a time
	start_only_in_idle: assert property (@(posedge cclk) disable iff (!rstb)
		conv_start |-> phase == PH_IDLE);

	clk_low_in_idle: assert property (@(posedge cclk) disable iff (!rstb)
		phase == PH_IDLE |-> !touch_clk);

endmodule

`default_nettype wire

/* logic/touch_scan_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "touch_macros.svh"

module touch_scan_sequencer (
	input wire cclk,
	input wire rstb,
	input wire conv_done,
	output logic conv_start,
	output touch_pkg::touch_cmd_u cmd,
	output logic sample_valid,
	output touch_pkg::channel_e sample_channel
);

	localparam int CNT_W = $clog2(`TOUCH_SETTLE_CONVERSIONS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TOUCH_SETTLE_CONVERSIONS - 1);

	touch_pkg::channel_e channel;
	logic [CNT_W-1:0] conv_cnt;
	logic started;

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			started <= 1'b0;
			conv_start <= 1'b0;
			conv_cnt <= '0;
			channel <= touch_pkg::CH_X;
			sample_valid <= 1'b0;
			sample_channel <= touch_pkg::CH_X;
		end else begin
			started <= 1'b1;
			conv_start <= !started || conv_done; // kick once, then back to back
			sample_valid <= 1'b0;
			if (conv_done) begin
				if (conv_cnt == CNT_LAST) begin
					conv_cnt <= '0;
					sample_valid <= 1'b1;
					sample_channel <= channel; // tag before switching
					case (channel)
						touch_pkg::CH_X: channel <= touch_pkg::CH_Y;
						touch_pkg::CH_Y: channel <= touch_pkg::CH_Z;
						default:         channel <= touch_pkg::CH_X;
					endcase
				end else begin
					conv_cnt <= conv_cnt + 1'b1;
				end
			end
		end
	end

	// control byte for the current channel
	always_comb begin
		cmd.f.start = 1'b1;
		case (channel)
			touch_pkg::CH_X: cmd.f.addr = 3'b101;
			touch_pkg::CH_Y: cmd.f.addr = 3'b001;
			default:         cmd.f.addr = 3'b011; // Z1 pressure
		endcase
		cmd.f.mode = 1'b0;
		cmd.f.ser_dfr = 1'b0;
		cmd.f.pd = 2'b11; // reference and ADC kept on
	end

	valid_single_cycle: assert property (@(posedge cclk) disable iff (!rstb)
		sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

/* logic/touch_position_filter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "touch_macros.svh"

module touch_position_filter (
	input wire cclk,
	input wire rstb,
	input wire sample_valid,
	input wire touch_pkg::channel_e sample_channel,
	input wire [11:0] conv_data,
	output wire [8:0] x,
	output wire [8:0] y,
	output wire [8:0] z
);

	logic [11:0] x_adj;
	logic [11:0] y_adj;
	logic [11:0] x_scaled;
	logic [11:0] y_scaled;
	logic [8:0] x_cond;
	logic [8:0] y_cond;
	logic [8:0] z_cond;
	logic ena_x;
	logic ena_y;
	logic ena_z;

	// offset removal, floored at zero
	assign x_adj = (conv_data > `TOUCH_X_ADJ_MIN) ? conv_data - `TOUCH_X_ADJ_MIN : 12'h000;
	assign y_adj = (conv_data > `TOUCH_Y_ADJ_MIN) ? conv_data - `TOUCH_Y_ADJ_MIN : 12'h000;

	// x by 1/8, y by roughly 1/13
	assign x_scaled = x_adj >> 3;
	assign y_scaled = (y_adj >> 4) + (y_adj >> 6);

	assign x_cond = (x_scaled > 12'(`TOUCH_X_MAX)) ? `TOUCH_X_MAX : x_scaled[8:0];
	assign y_cond = (y_scaled > 12'(`TOUCH_Y_MAX)) ? `TOUCH_Y_MAX : y_scaled[8:0];
	assign z_cond = conv_data[11:3];

	assign ena_x = sample_valid && (sample_channel == touch_pkg::CH_X);
	assign ena_y = sample_valid && (sample_channel == touch_pkg::CH_Y);
	assign ena_z = sample_valid && (sample_channel == touch_pkg::CH_Z);

	touch_averager #(
		.WIDTH(9),
		.LOG_DEPTH(`TOUCH_AVG_LOG_DEPTH)
	) u_avg_x (
		.cclk(cclk),
		.rstb(rstb),
		.ena(ena_x),
		.sample(x_cond),
		.average(x)
	);

	touch_averager #(
		.WIDTH(9),
		.LOG_DEPTH(`TOUCH_AVG_LOG_DEPTH)
	) u_avg_y (
		.cclk(cclk),
		.rstb(rstb),
		.ena(ena_y),
		.sample(y_cond),
		.average(y)
	);

	touch_averager #(
		.WIDTH(9),
		.LOG_DEPTH(`TOUCH_AVG_LOG_DEPTH)
	) u_avg_z (
		.cclk(cclk),
		.rstb(rstb),
		.ena(ena_z),
		.sample(z_cond),
		.average(z)
	);

endmodule

`default_nettype wire

/* logic/touch_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_controller (
	input wire cclk,
	input wire rstb,
	input wire touch_busy,
	input wire data_in,
	output wire touch_clk,
	output wire data_out,
	output wire touch_csb,
	output wire [8:0] x,
	output wire [8:0] y,
	output wire [8:0] z
);

	wire conv_start;
	wire conv_done;
	wire [11:0] conv_data;
	wire sample_valid;
	touch_pkg::touch_cmd_u cmd;
	touch_pkg::channel_e sample_channel;

	touch_serial_link u_link (
		.cclk(cclk),
		.rstb(rstb),
		.conv_start(conv_start),
		.cmd(cmd),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.touch_csb(touch_csb),
		.conv_done(conv_done),
		.conv_data(conv_data)
	);

	// runs beside the link, paced by conv_done
	touch_scan_sequencer u_seq (
		.cclk(cclk),
		.rstb(rstb),
		.conv_done(conv_done),
		.conv_start(conv_start),
		.cmd(cmd),
		.sample_valid(sample_valid),
		.sample_channel(sample_channel)
	);

	touch_position_filter u_filter (
		.cclk(cclk),
		.rstb(rstb),
		.sample_valid(sample_valid),
		.sample_channel(sample_channel),
		.conv_data(conv_data),
		.x(x),
		.y(y),
		.z(z)
	);

endmodule

`default_nettype wire

/* verification/touch_adc_model.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_adc_model (
	input wire cclk,
	input wire rstb,
	input wire touch_clk,
	input wire data_out,
	input wire [11:0] raw_x,
	input wire [11:0] raw_y,
	input wire [11:0] raw_z,
	output logic data_in,
	output logic touch_busy,
	output int served,
	output int cmd_errors
);

	localparam int BUSY_CLOCKS = 3; // serial clocks with busy high

	// control byte the sequencer should send for a channel
	function automatic logic [7:0] expected_cmd(input int ch);
		logic [2:0] addr;
		addr = (ch == 0) ? 3'b101 : (ch == 1) ? 3'b001 : 3'b011;
		return {1'b1, addr, 1'b0, 1'b0, 2'b11};
	endfunction

	initial begin
		logic prev_clk;
		logic [1:0] phase; // 0 command, 1 busy, 2 result
		logic skip_rise;
		logic [7:0] cmd_byte;
		logic [11:0] word;
		int bit_cnt;
		int busy_left;
		int run_cnt;
		int exp_ch;
		data_in = 1'b0;
		touch_busy = 1'b0;
		served = 0;
		cmd_errors = 0;
		prev_clk = 1'b0;
		cmd_byte = '0;
		forever begin
			@(negedge cclk);
			if (!rstb) begin
				phase = 2'd0;
				bit_cnt = 0;
				run_cnt = 0;
				exp_ch = 0;
				data_in = 1'b0;
				touch_busy = 1'b0;
			end else if (touch_clk && !prev_clk) begin
				case (phase)
					2'd0: begin
						cmd_byte = {cmd_byte[6:0], data_out};
						bit_cnt++;
						if (bit_cnt == 8) begin
							if (!cmd_byte[7] || cmd_byte != expected_cmd(exp_ch)) begin
								$display("error at time %0t: command byte %02h, expected %02h",
									$time, cmd_byte, expected_cmd(exp_ch));
								cmd_errors++;
							end
							run_cnt = (run_cnt == 7) ? 0 : run_cnt + 1;
							if (run_cnt == 0)
								exp_ch = (exp_ch + 1) % 3; // X, Y, Z in runs of eight
							case (cmd_byte[6:4])
								3'b101:  word = raw_x;
								3'b001:  word = raw_y;
								3'b011:  word = raw_z;
								default: word = '0;
							endcase
							touch_busy = 1'b1;
							busy_left = BUSY_CLOCKS;
							phase = 2'd1;
						end
					end
					2'd1: begin
						busy_left--;
						if (busy_left == 0) begin
							touch_busy = 1'b0;
							data_in = word[11];
							skip_rise = 1'b1; // link leaves busy wait on the next rise
							bit_cnt = 0;
							phase = 2'd2;
						end
					end
					default: begin
						if (skip_rise) begin
							skip_rise = 1'b0;
						end else if (bit_cnt == 11) begin
							data_in = 1'b0;
							bit_cnt = 0;
							served++;
							phase = 2'd0;
						end else begin
							data_in = word[10 - bit_cnt];
							bit_cnt++;
						end
					end
				endcase
			end
			prev_clk = touch_clk;
		end
	end

endmodule

`default_nettype wire

/* verification/touch_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "touch_macros.svh"

module touch_checker (
	input wire cclk,
	input wire rstb,
	input wire touch_csb,
	input wire touch_clk,
	input wire [8:0] x,
	input wire [8:0] y,
	input wire [8:0] z,
	input wire check_row,
	input wire check_step,
	input int row,
	input wire [11:0] raw_x,
	input wire [11:0] raw_y,
	input wire [11:0] raw_z,
	output int passes,
	output int fails
);

	function automatic int calc_x(input int raw);
		int adj;
		adj = (raw > int'(`TOUCH_X_ADJ_MIN)) ? raw - int'(`TOUCH_X_ADJ_MIN) : 0;
		return (adj / 8 > int'(`TOUCH_X_MAX)) ? int'(`TOUCH_X_MAX) : adj / 8;
	endfunction

	function automatic int calc_y(input int raw);
		int adj;
		adj = (raw > int'(`TOUCH_Y_ADJ_MIN)) ? raw - int'(`TOUCH_Y_ADJ_MIN) : 0;
		return (adj / 16 + adj / 64 > int'(`TOUCH_Y_MAX)) ? int'(`TOUCH_Y_MAX) : adj / 16 + adj / 64;
	endfunction

	function automatic int mismatch(input string name, input int got, input int want);
		if (got != want) begin
			$display("error at time %0t: %s is %0d, expected %0d", $time, name, got, want);
			return 1;
		end
		return 0;
	endfunction

	task automatic report(input string name, input int errs);
		if (errs == 0)
			passes++;
		else
			fails++;
		$display("test %0d %s %s", passes + fails, name, (errs == 0) ? "passed" : "failed");
	endtask

	initial begin
		int errs;
		int reset_errs;
		int reset_cycles;
		int after_reset;
		int want_x;
		int last_x;
		int lo;
		int hi;
		passes = 0;
		fails = 0;
		reset_errs = 0;
		reset_cycles = 0;
		after_reset = 0;
		last_x = 0;
		forever begin
			@(posedge cclk);
			if (!rstb) begin
				if (reset_cycles > 0) begin // flops settle on the first reset edge
					reset_errs += mismatch("touch_csb in reset", int'(touch_csb), 1);
					reset_errs += mismatch("touch_clk in reset", int'(touch_clk), 0);
					reset_errs += mismatch("x+y+z in reset", int'(x) + int'(y) + int'(z), 0);
				end
				reset_cycles++;
				after_reset = 0;
			end else if (after_reset < 2) begin
				after_reset++;
				if (after_reset == 2) begin
					reset_errs += mismatch("touch_csb after reset", int'(touch_csb), 0);
					reset_errs += mismatch("touch_clk after reset", int'(touch_clk), 0);
					reset_errs += mismatch("x+y+z after reset", int'(x) + int'(y) + int'(z), 0);
					report("reset", reset_errs);
				end
			end
			if (check_row) begin
				want_x = calc_x(int'(raw_x));
				errs = mismatch($sformatf("row %0d x", row), int'(x), want_x);
				errs += mismatch($sformatf("row %0d y", row), int'(y), calc_y(int'(raw_y)));
				errs += mismatch($sformatf("row %0d z", row), int'(z), int'(raw_z) / 8);
				last_x = want_x;
				report($sformatf("row %0d x=%0d y=%0d z=%0d", row, x, y, z), errs);
			end
			if (check_step) begin
				want_x = calc_x(int'(raw_x));
				lo = (last_x < want_x) ? last_x : want_x;
				hi = (last_x < want_x) ? want_x : last_x;
				errs = 0;
				// window mixes both rows, a wide step averages strictly inside
				if (hi - lo >= 8) begin
					lo++;
					hi--;
				end
				if (int'(x) < lo || int'(x) > hi) begin
					$display("error at time %0t: row %0d x is %0d mid step, expected %0d to %0d",
						$time, row, x, lo, hi);
					errs = 1;
				end
				report($sformatf("row %0d step x=%0d", row, x), errs);
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tb_touch_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_touch_controller;

	localparam int NUM_ROWS = 9;
	localparam int NUM_FIXED = 5;
	localparam int CMDS_PER_ROW = 256; // at least eight fresh kept samples per channel
	localparam int STEP_POINT = 128;
	localparam int WAIT_LIMIT = 400000; // cclk cycles

	logic cclk;
	logic rstb;
	logic touch_busy;
	logic data_in;
	wire touch_clk;
	wire data_out;
	wire touch_csb;
	wire [8:0] x;
	wire [8:0] y;
	wire [8:0] z;
	logic [11:0] raw_x;
	logic [11:0] raw_y;
	logic [11:0] raw_z;
	logic check_row;
	logic check_step;
	int row;
	int served;
	int cmd_errors;
	int passes;
	int fails;

	// raw x, y, z codes and a step flag per row
	logic [11:0] tab_x [NUM_ROWS];
	logic [11:0] tab_y [NUM_ROWS];
	logic [11:0] tab_z [NUM_ROWS];
	logic tab_step [NUM_ROWS];

	touch_controller dut0 (
		.cclk(cclk),
		.rstb(rstb),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.touch_csb(touch_csb),
		.x(x),
		.y(y),
		.z(z)
	);

	touch_adc_model adc0 (
		.cclk(cclk),
		.rstb(rstb),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.raw_x(raw_x),
		.raw_y(raw_y),
		.raw_z(raw_z),
		.data_in(data_in),
		.touch_busy(touch_busy),
		.served(served),
		.cmd_errors(cmd_errors)
	);

	touch_checker chk0 (
		.cclk(cclk),
		.rstb(rstb),
		.touch_csb(touch_csb),
		.touch_clk(touch_clk),
		.x(x),
		.y(y),
		.z(z),
		.check_row(check_row),
		.check_step(check_step),
		.row(row),
		.raw_x(raw_x),
		.raw_y(raw_y),
		.raw_z(raw_z),
		.passes(passes),
		.fails(fails)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic set_row(input int r, input logic [11:0] rx, input logic [11:0] ry,
		input logic [11:0] rz, input logic step);
		tab_x[r] = rx;
		tab_y[r] = ry;
		tab_z[r] = rz;
		tab_step[r] = step;
	endtask

	task automatic wait_served(input int target, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (served < target) begin
			if (cycles == WAIT_LIMIT) begin
				ok = 1'b0;
				break;
			end
			@(negedge cclk);
			cycles++;
		end
	endtask

	initial begin
		cclk = 1'b0;
		forever #4 cclk = ~cclk;
	end

	initial begin
		logic [31:0] seed;
		bit ok;
		bit timed_out;
		int base;
		rstb = 1'b0;
		raw_x = '0;
		raw_y = '0;
		raw_z = '0;
		check_row = 1'b0;
		check_step = 1'b0;
		row = 0;
		ok = 1'b1;
		timed_out = 1'b0;
		set_row(0, 12'h050, 12'h100, 12'h000, 1'b0); // below both offsets
		set_row(1, 12'h800, 12'h800, 12'h800, 1'b0);
		set_row(2, 12'hFFF, 12'hFFF, 12'hFFF, 1'b1); // clips at the screen edge
		set_row(3, 12'h096, 12'h12C, 12'h007, 1'b1); // exactly at the offsets
		set_row(4, 12'h400, 12'h600, 12'h9A5, 1'b0);
		seed = 32'h183d;
		for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
			seed = lcg_next(seed);
			tab_x[r] = seed[27:16];
			seed = lcg_next(seed);
			tab_y[r] = seed[27:16];
			seed = lcg_next(seed);
			tab_z[r] = seed[27:16];
			tab_step[r] = (r == NUM_FIXED);
		end
		repeat (2) @(negedge cclk);
		rstb = 1'b1;
		for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
			@(negedge cclk);
			raw_x = tab_x[r];
			raw_y = tab_y[r];
			raw_z = tab_z[r];
			row = r;
			base = served;
			if (tab_step[r]) begin
				wait_served(base + STEP_POINT, ok); // window holds old and new samples here
				check_step = ok;
				@(negedge cclk);
				check_step = 1'b0;
			end
			if (ok)
				wait_served(base + CMDS_PER_ROW, ok);
			check_row = ok;
			@(negedge cclk);
			check_row = 1'b0;
			timed_out = !ok;
		end
		repeat (2) @(negedge cclk);
		if (timed_out)
			$display("timeout: converter model served %0d commands, stuck at row %0d", served, row);
		$display("tests passed %0d, tests failed %0d, command errors %0d", passes, fails, cmd_errors);
		if (!timed_out && fails == 0 && cmd_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
logic/touch_pkg.sv
logic/touch_averager.sv
logic/touch_serial_link.sv
logic/touch_scan_sequencer.sv
logic/touch_position_filter.sv
logic/touch_controller.sv
verification/touch_adc_model.sv
verification/touch_checker.sv
verification/tb_touch_controller.sv

/* Makefile */
VERILATOR := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS := --binary --timing --assert
TOP := tb_touch_controller
FILE_LIST := list.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
